// ==== logic/pkt_fifo_macros.svh ====
// width, depth and threshold macros for the packet FIFO
`ifndef PKT_FIFO_MACROS_SVH
`define PKT_FIFO_MACROS_SVH

// byte lanes per beat
`define DATA_BYTES 4
`define DATA_BITS (`DATA_BYTES*8)

// async FIFO entries, power of two
`define FIFO_DEPTH 64
`define FIFO_ADDR_BITS $clog2(`FIFO_DEPTH)

// discard buffer entries, power of two
`define PKT_BUF_DEPTH 32
`define BUF_ADDR_BITS $clog2(`PKT_BUF_DEPTH)

// longest packet the design is sized for, in beats
`define MAX_PKT_BEATS 16

// free-entry margin that stops the discard drain
`define ALMOST_FULL_THRESH 4

// one stored beat: last, keep per lane, data
`define ENTRY_BITS (`DATA_BITS + `DATA_BYTES + 1)

`endif

// ==== logic/pkt_fifo_pkg.sv ====
// Gray-code pointer conversions and beat-entry pack/unpack functions
`include "pkt_fifo_macros.svh"

package pkt_fifo_pkg;

   // --------------------
   // pointer conversions
   // --------------------

   // pointers carry one extra wrap bit above the address
   function automatic logic [`FIFO_ADDR_BITS:0] bin_to_gray(
      input logic [`FIFO_ADDR_BITS:0] bin
   );
      return bin ^ (bin >> 1);
   endfunction

   function automatic logic [`FIFO_ADDR_BITS:0] gray_to_bin(
      input logic [`FIFO_ADDR_BITS:0] gray
   );
      logic [`FIFO_ADDR_BITS:0] bin;
      bin[`FIFO_ADDR_BITS] = gray[`FIFO_ADDR_BITS];
      // each binary bit folds in all gray bits above it
      for (int i = `FIFO_ADDR_BITS - 1; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

   // --------------------
   // entry layout
   // --------------------

   // last on top, keep in the middle, data at the bottom
   function automatic logic [`ENTRY_BITS-1:0] pack_entry(
      input logic                   last,
      input logic [`DATA_BYTES-1:0] keep,
      input logic [`DATA_BITS-1:0]  data
   );
      return {last, keep, data};
   endfunction

   function automatic logic entry_last(input logic [`ENTRY_BITS-1:0] entry);
      return entry[`ENTRY_BITS-1];
   endfunction

   function automatic logic [`DATA_BYTES-1:0] entry_keep(input logic [`ENTRY_BITS-1:0] entry);
      return entry[`DATA_BITS +: `DATA_BYTES];
   endfunction

   function automatic logic [`DATA_BITS-1:0] entry_data(input logic [`ENTRY_BITS-1:0] entry);
      return entry[`DATA_BITS-1:0];
   endfunction

endpackage

// ==== logic/sync_reset.sv ====
// reset synchronizer carrying the active-low reset into the clk_out domain
`timescale 1ns/100ps

module sync_reset (
   input  logic clk_out,
   input  logic rst_n,
   output logic out_rst_n
);

   // first stage of the release chain
   logic rst_meta;

   // --------------------
   // assert at once, release on clk_out
   // --------------------

   // rst_n comes from the aclk domain, so it is only trusted
   // after two clk_out flops on the way out of reset
   always_ff @(posedge clk_out or negedge rst_n) begin
      if (!rst_n) begin
         rst_meta  <= 1'b0;
         out_rst_n <= 1'b0;
      end else begin
         // ones shift in after release
         rst_meta  <= 1'b1;
         out_rst_n <= rst_meta;
      end
   end

   // out_rst_n goes high on the second clk_out edge
   // after rst_n has gone high
   // read side logic uses it as a plain synchronous reset

endmodule

// ==== logic/fifo_async.sv ====
// dual-clock first-word-fall-through FIFO with Gray pointers and fill counts
`timescale 1ns/100ps
`include "pkt_fifo_macros.svh"

module fifo_async (
   // write side, aclk domain
   input  logic                     aclk,
   input  logic                     rst_n,
   input  logic                     wr,
   input  logic [`ENTRY_BITS-1:0]   wr_data,
   output logic [`FIFO_ADDR_BITS:0] wr_count,
   // read side, clk_out domain
   input  logic                     clk_out,
   input  logic                     out_rst_n,
   input  logic                     rd,
   output logic [`ENTRY_BITS-1:0]   rd_data,
   output logic                     empty
);
   import pkt_fifo_pkg::*;

   localparam int AW = `FIFO_ADDR_BITS;

   // storage, no reset on payload
   logic [`ENTRY_BITS-1:0] mem [`FIFO_DEPTH];

   // write side pointers
   logic [AW:0] wr_ptr_bin;
   logic [AW:0] wr_ptr_next;
   logic [AW:0] wr_ptr_gray;

   // read pointer seen from aclk
   logic [AW:0] rd_gray_meta;
   logic [AW:0] rd_gray_sync;

   // read side pointers
   logic [AW:0] rd_ptr_bin;
   logic [AW:0] rd_ptr_next;
   logic [AW:0] rd_ptr_gray;
   logic        rd_fire;

   // write pointer seen from clk_out
   logic [AW:0] wr_gray_meta;
   logic [AW:0] wr_gray_sync;

   // --------------------
   // write side
   // --------------------

   assign wr_ptr_next = wr_ptr_bin + 1'b1;

   // memory write port
   always_ff @(posedge aclk) begin
      if (wr) begin
         mem[wr_ptr_bin[AW-1:0]] <= wr_data;
      end
   end

   // binary pointer addresses the memory
   // gray copy is what crosses to clk_out
   always_ff @(posedge aclk) begin
      if (!rst_n) begin
         wr_ptr_bin  <= '0;
         wr_ptr_gray <= '0;
      end else if (wr) begin
         wr_ptr_bin  <= wr_ptr_next;
         wr_ptr_gray <= bin_to_gray(wr_ptr_next);
      end
   end

   // two-flop sync of the read pointer
   always_ff @(posedge aclk) begin
      if (!rst_n) begin
         rd_gray_meta <= '0;
         rd_gray_sync <= '0;
      end else begin
         rd_gray_meta <= rd_ptr_gray;
         rd_gray_sync <= rd_gray_meta;
      end
   end

   // fill level as the writer sees it
   // lags reads, so it only ever overstates the fill
   assign wr_count = wr_ptr_bin - gray_to_bin(rd_gray_sync);

   // --------------------
   // read side
   // --------------------

   // a read against an empty FIFO is ignored
   assign rd_fire     = rd && !empty;
   assign rd_ptr_next = rd_ptr_bin + 1'b1;

   always_ff @(posedge clk_out) begin
      if (!out_rst_n) begin
         rd_ptr_bin  <= '0;
         rd_ptr_gray <= '0;
      end else if (rd_fire) begin
         rd_ptr_bin  <= rd_ptr_next;
         rd_ptr_gray <= bin_to_gray(rd_ptr_next);
      end
   end

   // two-flop sync of the write pointer
   always_ff @(posedge clk_out) begin
      if (!out_rst_n) begin
         wr_gray_meta <= '0;
         wr_gray_sync <= '0;
      end else begin
         wr_gray_meta <= wr_ptr_gray;
         wr_gray_sync <= wr_gray_meta;
      end
   end

   // equal gray pointers, wrap bit included, means nothing stored
   assign empty = (rd_ptr_gray == wr_gray_sync);

   // fall-through read, head entry is always on rd_data
   // valid whenever empty is low
   assign rd_data = mem[rd_ptr_bin[AW-1:0]];

   // an entry written on aclk is visible here only after
   // its pointer has passed both sync flops, so the memory
   // word has long settled by the time empty drops

endmodule

// ==== logic/pkt_discard_ovfl.sv ====
// store-and-forward packet buffer that commits whole packets and drops overflowed ones
`timescale 1ns/100ps
`include "pkt_fifo_macros.svh"

module pkt_discard_ovfl (
   input  logic                    aclk,
   input  logic                    rst_n,
   // ingress, no back-pressure
   input  logic                    in_tvalid,
   input  logic [`DATA_BITS-1:0]   in_tdata,
   input  logic [`DATA_BYTES-1:0]  in_tkeep,
   input  logic                    in_tlast,
   // toward the async FIFO
   input  logic                    fifo_almost_full,
   output logic                    fifo_wr,
   output logic [`ENTRY_BITS-1:0]  fifo_wr_data,
   // dropped packet count, saturating
   output logic [15:0]             drop_count
);
   import pkt_fifo_pkg::*;

   localparam int AW = `BUF_ADDR_BITS;

   // ring buffer, payload only
   logic [`ENTRY_BITS-1:0] buf_mem [`PKT_BUF_DEPTH];

   // tentative write, commit and read pointers, with wrap bit
   logic [AW:0] wr_ptr;
   logic [AW:0] cmt_ptr;
   logic [AW:0] rd_ptr;

   logic [AW:0] buf_used;
   logic        buf_full;

   // current packet has lost a beat
   logic        drop_mark;

   logic        beat_store;
   logic        pkt_commit;
   logic        pkt_drop;

   // --------------------
   // occupancy
   // --------------------

   // tentative entries count too, they hold space until dropped
   assign buf_used = wr_ptr - rd_ptr;
   assign buf_full = (buf_used == (AW+1)'(`PKT_BUF_DEPTH));

   // beats of a packet already marked are not stored
   assign beat_store = in_tvalid && !buf_full && !drop_mark;

   // last beat decides the packet's fate
   assign pkt_drop   = in_tvalid && in_tlast && (drop_mark || buf_full);
   assign pkt_commit = in_tvalid && in_tlast && !pkt_drop;

   // --------------------
   // ingress side
   // --------------------

   always_ff @(posedge aclk) begin
      if (beat_store) begin
         buf_mem[wr_ptr[AW-1:0]] <= pack_entry(in_tlast, in_tkeep, in_tdata);
      end
   end

   always_ff @(posedge aclk) begin
      if (!rst_n) begin
         wr_ptr    <= '0;
         cmt_ptr   <= '0;
         drop_mark <= 1'b0;
      end else begin
         // a dropped packet gives its space back
         if (pkt_drop) begin
            wr_ptr <= cmt_ptr;
         end else if (beat_store) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         // commit takes the last beat stored on this edge
         if (pkt_commit) begin
            cmt_ptr <= wr_ptr + 1'b1;
         end
         // mark clears at every packet end
         if (in_tvalid && in_tlast) begin
            drop_mark <= 1'b0;
         end else if (in_tvalid && buf_full) begin
            drop_mark <= 1'b1;
         end
      end
   end

   // holds at all ones instead of wrapping
   always_ff @(posedge aclk) begin
      if (!rst_n) begin
         drop_count <= '0;
      end else if (pkt_drop && (drop_count != 16'hffff)) begin
         drop_count <= drop_count + 16'd1;
      end
   end

   // --------------------
   // drain side
   // --------------------

   // only committed entries leave, so the FIFO never
   // sees part of a packet
   assign fifo_wr      = (rd_ptr != cmt_ptr) && !fifo_almost_full;
   assign fifo_wr_data = buf_mem[rd_ptr[AW-1:0]];

   always_ff @(posedge aclk) begin
      if (!rst_n) begin
         rd_ptr <= '0;
      end else if (fifo_wr) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

// ==== logic/pkt_fifo_async.sv ====
// top level: discard stage, async FIFO, reset synchronizer and flow control
`timescale 1ns/100ps
`include "pkt_fifo_macros.svh"

module pkt_fifo_async (
   // ingress, aclk domain
   input  logic                    aclk,
   input  logic                    rst_n,
   input  logic                    in_tvalid,
   input  logic [`DATA_BITS-1:0]   in_tdata,
   input  logic [`DATA_BYTES-1:0]  in_tkeep,
   input  logic                    in_tlast,
   // egress, clk_out domain
   input  logic                    clk_out,
   input  logic                    out_tready,
   output logic                    out_tvalid,
   output logic [`DATA_BITS-1:0]   out_tdata,
   output logic [`DATA_BYTES-1:0]  out_tkeep,
   output logic                    out_tlast,
   // flow control and status, aclk domain
   input  logic [15:0]             flow_ctl_thresh,
   output logic                    flow_ctl,
   output logic [15:0]             drop_count
);
   import pkt_fifo_pkg::*;

   // discard stage to FIFO
   logic                     fifo_wr;
   logic [`ENTRY_BITS-1:0]   fifo_wr_data;
   logic                     fifo_almost_full;
   logic [`FIFO_ADDR_BITS:0] wr_count;
   logic [15:0]              wr_count_ext;

   // FIFO read side
   logic                     rd;
   logic [`ENTRY_BITS-1:0]   rd_data;
   logic                     empty;
   logic                     out_rst_n;

   // --------------------
   // packet discard stage
   // --------------------

   pkt_discard_ovfl u_discard (
      .aclk             (aclk),
      .rst_n            (rst_n),
      .in_tvalid        (in_tvalid),
      .in_tdata         (in_tdata),
      .in_tkeep         (in_tkeep),
      .in_tlast         (in_tlast),
      .fifo_almost_full (fifo_almost_full),
      .fifo_wr          (fifo_wr),
      .fifo_wr_data     (fifo_wr_data),
      .drop_count       (drop_count)
   );

   // margin keeps in-flight writes clear of a full FIFO
   assign fifo_almost_full =
      wr_count > (`FIFO_ADDR_BITS+1)'(`FIFO_DEPTH - `ALMOST_FULL_THRESH);

   // --------------------
   // clock crossing
   // --------------------

   sync_reset u_sync_reset (
      .clk_out   (clk_out),
      .rst_n     (rst_n),
      .out_rst_n (out_rst_n)
   );

   fifo_async u_fifo (
      .aclk      (aclk),
      .rst_n     (rst_n),
      .wr        (fifo_wr),
      .wr_data   (fifo_wr_data),
      .wr_count  (wr_count),
      .clk_out   (clk_out),
      .out_rst_n (out_rst_n),
      .rd        (rd),
      .rd_data   (rd_data),
      .empty     (empty)
   );

   // --------------------
   // egress
   // --------------------

   // head entry is shown while not empty, pops on handshake
   assign out_tvalid = !empty;
   assign rd         = out_tready && out_tvalid;
   assign out_tdata  = entry_data(rd_data);
   assign out_tkeep  = entry_keep(rd_data);
   assign out_tlast  = entry_last(rd_data);

   // --------------------
   // flow control
   // --------------------

   assign wr_count_ext = 16'(wr_count);

   // registered compare against the run-time threshold
   always_ff @(posedge aclk) begin
      if (!rst_n) begin
         flow_ctl <= 1'b0;
      end else begin
         flow_ctl <= (wr_count_ext > flow_ctl_thresh);
      end
   end

endmodule

// ==== bench/pkt_fifo_async_tb.sv ====
// packet FIFO testbench with random packets, a queue model, egress and counter checks
`timescale 1ns/100ps
`include "pkt_fifo_macros.svh"

module pkt_fifo_async_tb;

   localparam int N_LOW      = 20;
   localparam int N_STALL    = 30;
   localparam int N_OVFL     = 14;
   localparam int BIG_BEATS  = `PKT_BUF_DEPTH + 4;
   localparam int FLOW_BEATS = 40;
   // upper bound on beats sent over all tests
   localparam int BEAT_BUDGET = (N_LOW + N_OVFL + 2) * `MAX_PKT_BEATS + N_STALL * 4
                                + BIG_BEATS + FLOW_BEATS;
   // 40 aclk periods per beat plus a fixed margin
   localparam real WATCHDOG_NS = BEAT_BUDGET * 40 * 10.0 + 20000.0;

   logic aclk, clk_out, rst_n;
   logic in_tvalid, in_tlast;
   logic [`DATA_BITS-1:0] in_tdata;
   logic [`DATA_BYTES-1:0] in_tkeep;
   logic out_tready, out_tvalid, out_tlast, flow_ctl;
   logic [`DATA_BITS-1:0] out_tdata;
   logic [`DATA_BYTES-1:0] out_tkeep;
   logic [15:0] flow_ctl_thresh, drop_count;

   integer seed = 32'hfca70f2a;
   // egress ready mode is 0 for low, 1 for high and 2 for random
   int ready_mode = 1;
   int errors = 0;
   int tests_run = 0;
   int tests_failed = 0;
   int sent_total = 0;
   int delivered_total = 0;
   int skip_total = 0;
   int pkt_num = 0;
   int last_skip_id = -1;
   int big_id;
   string cur_test;
   int err_base, sent_base, dlv_base, skip_base;
   logic [15:0] drop_base;

   // model keeps one entry per sent packet with its beats in flat queues
   int model_id[$];
   int model_len[$];
   logic [`DATA_BITS-1:0] model_data[$];
   logic [`DATA_BYTES-1:0] model_keep[$];
   // packet being rebuilt at the egress
   logic [`DATA_BITS-1:0] got_data[$];
   logic [`DATA_BYTES-1:0] got_keep[$];

   pkt_fifo_async dut (
      .aclk            (aclk),
      .rst_n           (rst_n),
      .in_tvalid       (in_tvalid),
      .in_tdata        (in_tdata),
      .in_tkeep        (in_tkeep),
      .in_tlast        (in_tlast),
      .clk_out         (clk_out),
      .out_tready      (out_tready),
      .out_tvalid      (out_tvalid),
      .out_tdata       (out_tdata),
      .out_tkeep       (out_tkeep),
      .out_tlast       (out_tlast),
      .flow_ctl_thresh (flow_ctl_thresh),
      .flow_ctl        (flow_ctl),
      .drop_count      (drop_count)
   );

   // --------------------
   // clocks, ready and watchdog
   // --------------------

   initial begin
      aclk = 1'b0;
      forever #5 aclk = ~aclk;
   end

   initial begin
      clk_out = 1'b0;
      forever #7 clk_out = ~clk_out;
   end

   // random mode keeps ready high three cycles in four
   always @(negedge clk_out) begin
      case (ready_mode)
         0: out_tready = 1'b0;
         1: out_tready = 1'b1;
         default: out_tready = (($random(seed) % 4) != 0);
      endcase
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: egress did not account for all sent packets in %0t", $time);
      $display("Finished with errors");
      $finish;
   end

   // --------------------
   // stimulus
   // --------------------

   function automatic int rand_range(input int lo, input int hi);
      return lo + ($unsigned($random(seed)) % (hi - lo + 1));
   endfunction

   task automatic idle(input int cycles);
      repeat (cycles) begin
         @(negedge aclk);
         in_tvalid = 1'b0;
         in_tlast  = 1'b0;
      end
   endtask

   // first word carries the packet number and the rest is random
   task automatic send_packet(input int len, input int gap);
      logic [`DATA_BITS-1:0] word;
      logic [`DATA_BYTES-1:0] keep;
      model_id.push_back(pkt_num);
      model_len.push_back(len);
      for (int b = 0; b < len; b++) begin
         @(negedge aclk);
         word = (b == 0) ? pkt_num : $random(seed);
         keep = `DATA_BYTES'($random(seed));
         model_data.push_back(word);
         model_keep.push_back(keep);
         in_tvalid = 1'b1;
         in_tdata  = word;
         in_tkeep  = keep;
         in_tlast  = (b == len - 1);
      end
      pkt_num++;
      sent_total++;
      idle(gap);
   endtask

   // --------------------
   // model and egress monitor
   // --------------------

   task automatic skip_model_packet();
      int len;
      len = model_len[0];
      last_skip_id = model_id[0];
      model_len.delete(0);
      model_id.delete(0);
      repeat (len) begin
         model_data.delete(0);
         model_keep.delete(0);
      end
      skip_total++;
   endtask

   // packets the DUT dropped are skipped until the number matches
   task automatic check_packet();
      int id;
      int len;
      int i;
      id = got_data[0];
      while (model_id.size() > 0 && model_id[0] != id) skip_model_packet();
      if (model_id.size() == 0) begin
         errors++;
         $display("Error in %s: egress packet %0d matches no packet still expected",
                  cur_test, id);
      end else begin
         len = model_len[0];
         if (got_data.size() != len) begin
            errors++;
            $display("Fail %s: packet %0d length expected %0d actual %0d",
                     cur_test, id, len, got_data.size());
         end
         for (i = 0; i < len && i < got_data.size(); i++) begin
            if (got_data[i] !== model_data[i] || got_keep[i] !== model_keep[i]) begin
               errors++;
               $display("Fail %s: packet %0d beat %0d keep/data expected %h/%h actual %h/%h",
                        cur_test, id, i, model_keep[i], model_data[i], got_keep[i], got_data[i]);
            end
         end
         model_id.delete(0);
         model_len.delete(0);
         repeat (len) begin
            model_data.delete(0);
            model_keep.delete(0);
         end
         delivered_total++;
      end
   endtask

   always @(posedge clk_out) begin
      if (out_tvalid && out_tready) begin
         got_data.push_back(out_tdata);
         got_keep.push_back(out_tkeep);
         if (out_tlast) begin
            check_packet();
            got_data.delete();
            got_keep.delete();
         end
      end
   end

   // --------------------
   // test bookkeeping
   // --------------------

   task automatic start_test(input string name);
      cur_test  = name;
      err_base  = errors;
      sent_base = sent_total;
      dlv_base  = delivered_total;
      skip_base = skip_total;
      drop_base = drop_count;
   endtask

   // negative expectations mean any value is accepted
   task automatic end_test(input int exp_drops, input int exp_skip_id);
      int drops, sent, dlv, skips;
      // every sent packet ends up delivered or counted as dropped
      while (delivered_total + drop_count != sent_total) @(negedge aclk);
      while (model_id.size() > 0) skip_model_packet();
      drops = drop_count - drop_base;
      sent  = sent_total - sent_base;
      dlv   = delivered_total - dlv_base;
      skips = skip_total - skip_base;
      if (drops != skips) begin
         errors++;
         $display("Fail %s: drop_count rise expected %0d actual %0d", cur_test, skips, drops);
      end
      if (exp_drops >= 0 && drops != exp_drops) begin
         errors++;
         $display("Fail %s: drops expected %0d actual %0d", cur_test, exp_drops, drops);
      end
      if (exp_skip_id >= 0 && last_skip_id != exp_skip_id) begin
         errors++;
         $display("Fail %s: dropped packet expected %0d actual %0d",
                  cur_test, exp_skip_id, last_skip_id);
      end
      tests_run++;
      if (errors != err_base) tests_failed++;
      $display("test %s %s  sent %0d delivered %0d dropped %0d", cur_test,
               (errors == err_base) ? "passed" : "FAILED", sent, dlv, drops);
   endtask

   // --------------------
   // test sequence
   // --------------------

   initial begin
      rst_n           = 1'b0;
      in_tvalid       = 1'b0;
      in_tdata        = '0;
      in_tkeep        = '0;
      in_tlast        = 1'b0;
      out_tready      = 1'b0;
      flow_ctl_thresh = 16'd32;

      // first check falls inside reset and the rest right after release
      repeat (5) @(posedge aclk);
      start_test("reset_state");
      for (int k = 0; k < 5; k++) begin
         @(negedge aclk);
         if ({out_tvalid, flow_ctl, drop_count} !== '0) begin
            errors++;
            $display("Fail %s: {out_tvalid,flow_ctl,drop_count} cycle %0d expected 0 actual %h",
                     cur_test, k, {out_tvalid, flow_ctl, drop_count});
         end
         rst_n = 1'b1;
      end
      end_test(0, -1);

      start_test("low_rate");
      ready_mode = 1;
      repeat (N_LOW) send_packet(rand_range(1, `MAX_PKT_BEATS), rand_range(4, 12));
      end_test(0, -1);

      start_test("egress_stall");
      ready_mode = 2;
      repeat (N_STALL) send_packet(rand_range(1, 4), rand_range(2, 6));
      end_test(0, -1);

      // FIFO and discard buffer both fill and later packets drop
      start_test("overflow");
      ready_mode = 0;
      repeat (N_OVFL) send_packet(rand_range(8, `MAX_PKT_BEATS), 0);
      idle(20);
      ready_mode = 1;
      end_test(-1, -1);

      start_test("oversized");
      ready_mode = 1;
      send_packet(rand_range(1, `MAX_PKT_BEATS), 4);
      big_id = pkt_num;
      send_packet(BIG_BEATS, 4);
      send_packet(rand_range(1, `MAX_PKT_BEATS), 4);
      end_test(1, big_id);

      // five packets of 8 beats sit in the FIFO with the egress stalled
      start_test("flow_ctl");
      ready_mode = 0;
      flow_ctl_thresh = 16'd30;
      repeat (FLOW_BEATS / 8) send_packet(8, 1);
      idle(20);
      if (flow_ctl !== (FLOW_BEATS > flow_ctl_thresh)) begin
         errors++;
         $display("Fail %s: flow_ctl at thresh %0d expected %b actual %b", cur_test,
                  flow_ctl_thresh, (FLOW_BEATS > flow_ctl_thresh), flow_ctl);
      end
      flow_ctl_thresh = 16'd50;
      idle(20);
      if (flow_ctl !== (FLOW_BEATS > flow_ctl_thresh)) begin
         errors++;
         $display("Fail %s: flow_ctl at thresh %0d expected %b actual %b", cur_test,
                  flow_ctl_thresh, (FLOW_BEATS > flow_ctl_thresh), flow_ctl);
      end
      ready_mode = 1;
      end_test(0, -1);

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+logic
logic/pkt_fifo_pkg.sv
logic/sync_reset.sv
logic/fifo_async.sv
logic/pkt_discard_ovfl.sv
logic/pkt_fifo_async.sv
bench/pkt_fifo_async_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the packet FIFO testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f project.f --top-module pkt_fifo_async_tb &&
./obj_dir/Vpkt_fifo_async_tb | tee /dev/stderr | grep -x "Finished with no errors" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
